//--- include/tetris_macros.svh
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// board size with row 0 at the top
`define BOARD_ROWS 22
`define BOARD_COLS 10
// rows where pieces are drawn and full rows are cleared
`define FLOOR_ROWS 20

// index widths for anchor, probe rows and columns
`define ROW_W 5
`define COL_W 4
`define LINES_W 3

// lowest anchor row per shape so the bottom cell lands on row 19
`define MAX_ROW_LINE   5'd16
`define MAX_ROW_SQUARE 5'd18
`define MAX_ROW_L      5'd17
`define MAX_ROW_FLAT   5'd18
`define MAX_ROW_NONE   5'd19

`endif

//--- hdl/tetris_pkg.sv
`default_nettype none

`include "tetris_macros.svh"

package tetris_pkg;

    // value 7 is left unused and draws nothing
    typedef enum logic [2:0] {
        LINE   = 3'd0,
        SQUARE = 3'd1,
        L      = 3'd2,
        REV_L  = 3'd3,
        S      = 3'd4,
        Z      = 3'd5,
        T      = 3'd6
    } piece_kind_t;

    // one bit per cell, board[row][col]
    typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board_t;

    // cells just under the lowest cell of each piece column
    // row0 goes with col0, row1 with col1 and col2
    typedef struct packed {
        logic [`ROW_W-1:0] row0;
        logic [`ROW_W-1:0] row1;
        logic [`COL_W-1:0] col0;
        logic [`COL_W-1:0] col1;
        logic [`COL_W-1:0] col2;
        logic [2:0]        used;
    } probe_t;

endpackage

`default_nettype wire

//--- hdl/piece_drop.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module piece_drop (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    spawn,
    input  logic                    step,
    input  tetris_pkg::piece_kind_t spawn_kind,
    input  logic [`COL_W-1:0]       spawn_col,
    input  logic                    blocked,
    output tetris_pkg::board_t      piece_cells,
    output tetris_pkg::probe_t      probe,
    output logic                    lock,
    output logic                    falling
);
    import tetris_pkg::*;

    piece_kind_t       kind;
    logic [`COL_W-1:0] col;
    logic [`ROW_W-1:0] row;
    logic [`ROW_W-1:0] max_row;
    logic              shape_ok;
    logic              at_floor;
    // row and column offset of each of the four cells
    logic [3:0][1:0]   dr;
    logic [3:0][1:0]   dc;
    // probe row offsets and probe column offsets
    logic [1:0][2:0]   pr;
    logic [2:0][1:0]   pc;
    logic [2:0]        used;

    // shape table and floor limit per kind
    always_comb begin
        dr       = '0;
        dc       = '0;
        pr       = '0;
        pc       = '0;
        used     = '0;
        max_row  = `MAX_ROW_NONE;
        shape_ok = 1'b1;
        case (kind)
            LINE: begin
                dr      = {2'd3, 2'd2, 2'd1, 2'd0};
                pr      = {3'd0, 3'd4};
                used    = 3'b001;
                max_row = `MAX_ROW_LINE;
            end
            SQUARE: begin
                dr      = {2'd1, 2'd1, 2'd0, 2'd0};
                dc      = {2'd1, 2'd0, 2'd1, 2'd0};
                pr      = {3'd2, 3'd2};
                pc      = {2'd0, 2'd1, 2'd0};
                used    = 3'b011;
                max_row = `MAX_ROW_SQUARE;
            end
            L: begin
                dr      = {2'd2, 2'd2, 2'd1, 2'd0};
                dc      = {2'd1, 2'd0, 2'd0, 2'd0};
                pr      = {3'd3, 3'd3};
                pc      = {2'd0, 2'd1, 2'd0};
                used    = 3'b011;
                max_row = `MAX_ROW_L;
            end
            REV_L: begin
                dr      = {2'd2, 2'd2, 2'd1, 2'd0};
                dc      = {2'd0, 2'd1, 2'd1, 2'd1};
                pr      = {3'd3, 3'd3};
                pc      = {2'd0, 2'd1, 2'd0};
                used    = 3'b011;
                max_row = `MAX_ROW_L;
            end
            S: begin
                // right column sits one row higher than the other two
                dr      = {2'd1, 2'd1, 2'd0, 2'd0};
                dc      = {2'd1, 2'd0, 2'd2, 2'd1};
                pr      = {3'd2, 3'd1};
                pc      = {2'd1, 2'd0, 2'd2};
                used    = 3'b111;
                max_row = `MAX_ROW_FLAT;
            end
            Z: begin
                dr      = {2'd1, 2'd1, 2'd0, 2'd0};
                dc      = {2'd2, 2'd1, 2'd1, 2'd0};
                pr      = {3'd2, 3'd1};
                pc      = {2'd2, 2'd1, 2'd0};
                used    = 3'b111;
                max_row = `MAX_ROW_FLAT;
            end
            T: begin
                dr      = {2'd1, 2'd1, 2'd1, 2'd0};
                dc      = {2'd2, 2'd1, 2'd0, 2'd1};
                pr      = {3'd2, 3'd2};
                pc      = {2'd2, 2'd1, 2'd0};
                used    = 3'b111;
                max_row = `MAX_ROW_FLAT;
            end
            default: begin
                shape_ok = 1'b0;
            end
        endcase
    end

    // draw the piece at the current anchor
    always_comb begin
        piece_cells = '0;
        if (falling && shape_ok) begin
            for (int i = 0; i < 4; i++) begin
                piece_cells[row + {3'b000, dr[i]}][col + {2'b00, dc[i]}] = 1'b1;
            end
        end
    end

    always_comb begin
        probe.row0 = row + {2'b00, pr[0]};
        probe.row1 = row + {2'b00, pr[1]};
        probe.col0 = col + {2'b00, pc[0]};
        probe.col1 = col + {2'b00, pc[1]};
        probe.col2 = col + {2'b00, pc[2]};
        probe.used = used;
    end

    assign at_floor = (row >= max_row);
    // step that cannot move the piece ends its fall
    assign lock = falling && step && (blocked || at_floor);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            falling <= 1'b0;
            row     <= '0;
        end else if (spawn && !falling) begin
            falling <= 1'b1;
            row     <= '0;
        end else if (lock) begin
            falling <= 1'b0;
        end else if (falling && step) begin
            row <= row + 5'd1;
        end
    end

    // kind and column latched at spawn
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kind <= LINE;
            col  <= '0;
        end else if (spawn && !falling) begin
            kind <= spawn_kind;
            col  <= spawn_col;
        end
    end

endmodule

`default_nettype wire

//--- hdl/stack_collide.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module stack_collide (
    input  tetris_pkg::board_t stack,
    input  tetris_pkg::probe_t probe,
    output logic               blocked
);
    import tetris_pkg::*;

    logic [2:0] hit;

    // rows past the floor are covered by the floor limit
    function automatic logic cell_taken(
        input board_t            b,
        input logic [`ROW_W-1:0] r,
        input logic [`COL_W-1:0] c
    );
        cell_taken = (r < `FLOOR_ROWS) && (c < `BOARD_COLS) && b[r][c];
    endfunction

    always_comb begin
        hit[0] = probe.used[0] && cell_taken(stack, probe.row0, probe.col0);
        hit[1] = probe.used[1] && cell_taken(stack, probe.row1, probe.col1);
        hit[2] = probe.used[2] && cell_taken(stack, probe.row1, probe.col2);
    end

    assign blocked = |hit;

endmodule

`default_nettype wire

//--- hdl/settled_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module settled_stack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lock,
    input  tetris_pkg::board_t   piece_cells,
    output tetris_pkg::board_t   stack,
    output logic                 locked,
    output logic [`LINES_W-1:0]  lines_cleared
);
    import tetris_pkg::*;

    board_t               merged;
    board_t               compacted;
    logic [`FLOOR_ROWS-1:0] full;
    logic [`LINES_W-1:0]  n_full;

    assign merged = stack | piece_cells;

    always_comb begin
        for (int r = 0; r < `FLOOR_ROWS; r++) begin
            full[r] = &merged[r];
        end
    end

    // walk up from the floor and pack the rows that stay
    always_comb begin
        int dst;
        compacted = '0;
        n_full    = '0;
        dst       = `FLOOR_ROWS - 1;
        for (int src = `FLOOR_ROWS - 1; src >= 0; src--) begin
            if (full[src]) begin
                n_full = n_full + 3'd1;
            end else begin
                compacted[dst] = merged[src];
                dst            = dst - 1;
            end
        end
        // rows under the floor are never cleared
        for (int r = `FLOOR_ROWS; r < `BOARD_ROWS; r++) begin
            compacted[r] = merged[r];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stack         <= '0;
            locked        <= 1'b0;
            lines_cleared <= '0;
        end else begin
            locked <= lock;
            if (lock) begin
                stack         <= compacted;
                lines_cleared <= n_full;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tetris_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetris_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    spawn,
    input  logic                    step,
    input  tetris_pkg::piece_kind_t spawn_kind,
    input  logic [`COL_W-1:0]       spawn_col,
    output tetris_pkg::board_t      board,
    output logic                    falling,
    output logic                    locked,
    output logic [`LINES_W-1:0]     lines_cleared
);
    import tetris_pkg::*;

    board_t stack;
    board_t piece_cells;
    probe_t probe;
    logic   blocked;
    logic   lock;

    piece_drop u_piece_drop (
        .clk         (clk),
        .rst         (rst),
        .spawn       (spawn),
        .step        (step),
        .spawn_kind  (spawn_kind),
        .spawn_col   (spawn_col),
        .blocked     (blocked),
        .piece_cells (piece_cells),
        .probe       (probe),
        .lock        (lock),
        .falling     (falling)
    );

    stack_collide u_stack_collide (
        .stack   (stack),
        .probe   (probe),
        .blocked (blocked)
    );

    settled_stack u_settled_stack (
        .clk           (clk),
        .rst           (rst),
        .lock          (lock),
        .piece_cells   (piece_cells),
        .stack         (stack),
        .locked        (locked),
        .lines_cleared (lines_cleared)
    );

    // falling piece shown over the settled stack
    assign board = stack | piece_cells;

endmodule

`default_nettype wire

//--- sim/tetris_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetris_asserts (
    input logic               clk,
    input logic               rst,
    input logic               falling,
    input logic               locked,
    input tetris_pkg::board_t board
);
    import tetris_pkg::*;

    // number of failed assertions so far
    int fail_count = 0;

    // locked lasts a single cycle
    locked_one_cycle: assert property (@(posedge clk) disable iff (rst)
        locked |=> !locked)
        else begin
            fail_count++;
            $error("locked held for more than one cycle");
        end

    // the piece stops falling at the edge that raises locked
    falling_drops: assert property (@(posedge clk) disable iff (rst)
        locked |-> !falling)
        else begin
            fail_count++;
            $error("falling still high while locked");
        end

    // nothing is ever drawn or settled below the floor rows
    floor_rows_empty: assert property (@(posedge clk) disable iff (rst)
        board[`BOARD_ROWS-1:`FLOOR_ROWS] == '0)
        else begin
            fail_count++;
            $error("cell set in rows under the floor");
        end

endmodule

bind tetris_core tetris_asserts u_tetris_asserts (
    .clk     (clk),
    .rst     (rst),
    .falling (falling),
    .locked  (locked),
    .board   (board)
);

`default_nettype wire

//--- sim/tetris_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetris_tb;
    import tetris_pkg::*;

    localparam int WAIT_LIMIT = 40;

    logic                clk;
    logic                rst;
    logic                spawn;
    logic                step;
    piece_kind_t         spawn_kind;
    logic [`COL_W-1:0]   spawn_col;
    board_t              board;
    logic                falling;
    logic                locked;
    logic [`LINES_W-1:0] lines_cleared;

    int                  lock_count;
    logic [`LINES_W-1:0] seen_lines;
    integer              seed;

    tetris_core u_tetris_core (
        .clk           (clk),
        .rst           (rst),
        .spawn         (spawn),
        .step          (step),
        .spawn_kind    (spawn_kind),
        .spawn_col     (spawn_col),
        .board         (board),
        .falling       (falling),
        .locked        (locked),
        .lines_cleared (lines_cleared)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // catch every locked pulse and the line count that comes with it
    always @(negedge clk) begin
        if (!rst && locked) begin
            lock_count = lock_count + 1;
            seen_lines = lines_cleared;
        end
    end

    // a failed bound assertion ends the run
    always @(negedge clk) begin
        if (u_tetris_core.u_tetris_asserts.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_board(input board_t got, input board_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s board got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "board compare");
        end
    endtask

    task automatic check_lines(input logic [`LINES_W-1:0] got,
                               input logic [`LINES_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s lines_cleared got %0d expected %0d",
                     $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "line count compare");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "flag compare");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "pulse count compare");
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) @(posedge clk);
    endtask

    task automatic pulse_step();
        @(posedge clk);
        step <= 1'b1;
        @(posedge clk);
        step <= 1'b0;
    endtask

    task automatic spawn_piece(input piece_kind_t kind, input logic [`COL_W-1:0] col);
        @(posedge clk);
        spawn      <= 1'b1;
        spawn_kind <= kind;
        spawn_col  <= col;
        @(posedge clk);
        spawn      <= 1'b0;
    endtask

    task automatic wait_falling();
        int cnt;
        cnt = 0;
        while (!falling) begin
            if (cnt >= WAIT_LIMIT) begin
                $display("timeout: falling never went high after spawn");
                $display("Test failed");
                $fatal(1, "falling timeout");
            end
            @(posedge clk);
            cnt++;
        end
    endtask

    task automatic wait_lock(input int target);
        int cnt;
        cnt = 0;
        while (lock_count < target) begin
            if (cnt >= WAIT_LIMIT) begin
                $display("timeout: locked never pulsed for the falling piece");
                $display("Test failed");
                $fatal(1, "locked timeout");
            end
            @(posedge clk);
            cnt++;
        end
    endtask

    initial begin
        int                  fd;
        int                  rc;
        int                  steps;
        int                  records;
        string               line;
        logic [2:0]          kind_val;
        logic [`COL_W-1:0]   col_val;
        logic [`LINES_W-1:0] exp_lines;
        logic [`BOARD_COLS-1:0] row_val;
        board_t              exp_board;

        seed       = 32'h226d;
        rst        = 1'b1;
        spawn      = 1'b0;
        step       = 1'b0;
        spawn_kind = LINE;
        spawn_col  = '0;
        lock_count = 0;
        seen_lines = '0;
        records    = 0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_board(board, '0, "after reset");
        check_flag(falling, 1'b0, "falling after reset");
        check_lines(lines_cleared, '0, "after reset");

        fd = $fopen("sim/tetris_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file sim/tetris_golden.txt");
            $display("Test failed");
            $fatal(1, "missing golden file");
        end

        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%h %h %d %d", kind_val, col_val, steps, exp_lines);
                if (rc != 4) begin
                    $display("golden file has a record header that cannot be read");
                    $display("Test failed");
                    $fatal(1, "bad golden header");
                end
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    rc = $fscanf(fd, "%h", row_val);
                    if (rc != 1) begin
                        $display("golden file has a board row that cannot be read");
                        $display("Test failed");
                        $fatal(1, "bad golden board");
                    end
                    exp_board[r] = row_val;
                end
                records++;

                spawn_piece(piece_kind_t'(kind_val), col_val);
                wait_falling();
                for (int s = 0; s < steps; s++) begin
                    idle_gap();
                    pulse_step();
                    // a second spawn in mid fall must be ignored
                    if (s == 0) begin
                        spawn_piece(LINE, 4'd5);
                    end
                end
                wait_lock(records);

                @(negedge clk);
                check_board(board, exp_board, $sformatf("record %0d", records));
                check_lines(seen_lines, exp_lines, $sformatf("record %0d", records));
                check_flag(falling, 1'b0, "falling after lock");
                check_count(lock_count, records, "locked pulses");
            end
        end
        $fclose(fd);

        if (records == 0) begin
            $display("golden file held no records");
            $display("Test failed");
            $fatal(1, "empty golden file");
        end else if (u_tetris_core.u_tetris_asserts.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hdl/tetris_pkg.sv
hdl/piece_drop.sv
hdl/stack_collide.sv
hdl/settled_stack.sv
hdl/tetris_core.sv
sim/tetris_asserts.sv
sim/tetris_tb.sv

//--- sim/tetris_golden.txt
# header line: kind col steps lines_cleared (kind and col in hex)
# next line: 22 board rows in hex, row 0 first, bit n is column n
0 0 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 001 001 001 001 000 000
0 1 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 003 003 003 003 000 000
1 2 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 003 003 00F 00F 000 000
1 4 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 003 003 03F 03F 000 000
1 6 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 003 003 0FF 0FF 000 000
1 8 20 2
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 003 003 000 000
6 0 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 002 007 003 003 000 000
4 3 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 002 007 033 01B 000 000
5 6 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 002 007 0F3 19B 000 000
3 8 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 202 207 3F3 19B 000 000
2 2 20 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 004 004 20E 207 3F3 19B 000 000
